/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    ////////////////////
    // line geometry

    localparam int LINE_W = 128; // 16 bytes per line

    typedef logic [LINE_W-1:0] line_t;

    ////////////////////
    // encodings

    // source that last loaded a fip register
    typedef enum logic [1:0] {
        SRC_SEQ  = 2'd0, // sequential advance after a take
        SRC_BP   = 2'd1, // branch predictor
        SRC_WB   = 2'd2, // write-back resteer
        SRC_INIT = 2'd3
    } fetch_src_e;

    // refill progress of one cache bank
    typedef enum logic [1:0] {
        ST_LOOKUP  = 2'd0, // normal tag compare
        ST_REQ     = 2'd1, // req raised, waiting on ack
        ST_RELEASE = 2'd2  // line written, waiting for ack to fall
    } bank_state_e;

endpackage

`default_nettype wire

/* common/refill_if.sv */
`default_nettype none

// one bank's refill channel toward the shared memory port
interface refill_if import fetch_pkg::*; #(
    parameter int ADDR_W = 32
) ();

    logic              req;       // bank wants a line
    logic [ADDR_W-5:0] line_addr; // line address, held while req is high
    logic              ack;       // line is valid
    line_t             line;

    modport bank (
        output req,
        output line_addr,
        input  ack,
        input  line
    );

    modport arbiter (
        input  req,
        input  line_addr,
        output ack,
        output line
    );

endinterface

`default_nettype wire

/* source/fetch_addr_sel.sv */
`default_nettype none

module fetch_addr_sel import fetch_pkg::*; #(
    parameter int ADDR_W = 32,
    parameter bit ODD    = 1'b0  // line parity this pointer serves
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              init_i,
    input  logic [ADDR_W-1:0] init_addr_i,
    input  logic              resteer_i,
    input  logic [ADDR_W-5:0] wb_fip_i,
    input  logic              br_taken_i,
    input  logic [ADDR_W-5:0] bp_fip_i,
    input  logic              take_i,
    output logic [ADDR_W-5:0] fip_o,
    output logic              fip_valid_o,
    output fetch_src_e        src_o
);

    localparam int FIP_W = ADDR_W - 4;

    logic [FIP_W-1:0] init_line;
    logic [FIP_W-1:0] init_fip;
    logic [FIP_W-1:0] fip_d;
    fetch_src_e       src_d;

    ////////////////////
    // init split

    assign init_line = init_addr_i[ADDR_W-1:4];

    // first line at or after the init line with our parity
    assign init_fip = (init_line[0] == ODD) ? init_line : init_line + FIP_W'(1);

    ////////////////////
    // next fip

    always_comb begin
        fip_d = fip_o;
        src_d = src_o;
        if (init_i) begin
            fip_d = init_fip;
            src_d = SRC_INIT;
        end else if (resteer_i) begin
            fip_d = wb_fip_i;
            src_d = SRC_WB;
        end else if (br_taken_i) begin
            fip_d = bp_fip_i;
            src_d = SRC_BP;
        end else if (take_i && fip_valid_o) begin
            fip_d = fip_o + FIP_W'(2); // skip the other bank's line
            src_d = SRC_SEQ;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fip_o       <= '0;
            fip_valid_o <= 1'b0;
            src_o       <= SRC_SEQ;
        end else begin
            fip_o <= fip_d;
            src_o <= src_d;
            if (init_i) begin
                fip_valid_o <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

/* icache/icache_bank.sv */
`default_nettype none

module icache_bank import fetch_pkg::*; #(
    parameter int ADDR_W  = 32,
    parameter int INDEX_W = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [ADDR_W-5:0] fip_i,
    input  logic              fip_valid_i,
    output line_t             line_o,
    output logic              valid_o,
    output logic              fill_o,
    refill_if.bank            refill
);

    localparam int FIP_W = ADDR_W - 4;
    localparam int TAG_W = FIP_W - INDEX_W;
    localparam int LINES = 1 << INDEX_W;

    ////////////////////
    // storage

    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [LINES];
    line_t            data_q [LINES];

    bank_state_e      state_q;
    bank_state_e      state_d;
    logic [FIP_W-1:0] miss_fip_q; // line being refilled

    logic [INDEX_W-1:0] rd_index;
    logic [TAG_W-1:0]   rd_tag;
    logic [INDEX_W-1:0] wr_index;
    logic               hit;
    logic               fill_write;

    ////////////////////
    // lookup

    assign rd_index = fip_i[INDEX_W-1:0];
    assign rd_tag   = fip_i[FIP_W-1:INDEX_W];
    assign hit      = fip_valid_i && valid_q[rd_index] && (tag_q[rd_index] == rd_tag);

    assign line_o  = data_q[rd_index];
    assign valid_o = (state_q == ST_LOOKUP) && hit;
    assign fill_o  = (state_q != ST_LOOKUP); // bank busy with a refill

    ////////////////////
    // refill

    assign wr_index   = miss_fip_q[INDEX_W-1:0];
    assign fill_write = (state_q == ST_REQ) && refill.ack;

    assign refill.req       = (state_q == ST_REQ);
    assign refill.line_addr = miss_fip_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP: begin
                if (fip_valid_i && !hit) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                if (refill.ack) begin
                    state_d = ST_RELEASE;
                end
            end
            ST_RELEASE: begin
                if (!refill.ack) begin
                    state_d = ST_LOOKUP; // handshake closed
                end
            end
            default: state_d = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_LOOKUP;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_write) begin
                valid_q[wr_index] <= 1'b1;
            end
        end
    end

    // miss address follows the fip until the bank leaves lookup,
    // so a redirect mid-refill cannot move the write target
    always_ff @(posedge clk) begin
        if (state_q == ST_LOOKUP) begin
            miss_fip_q <= fip_i;
        end
        if (fill_write) begin
            tag_q[wr_index]  <= miss_fip_q[FIP_W-1:INDEX_W];
            data_q[wr_index] <= refill.line;
        end
    end

endmodule

`default_nettype wire

/* icache/refill_arbiter.sv */
`default_nettype none

module refill_arbiter import fetch_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst_n_i,
    refill_if.arbiter         even,
    refill_if.arbiter         odd,
    output logic              mem_req_o,
    output logic [ADDR_W-5:0] mem_addr_o,
    input  logic              mem_ack_i,
    input  line_t             mem_line_i
);

    logic owner_q; // 0 even bank, 1 odd bank
    logic last_q;  // bank of the last completed handshake
    logic owner_d;
    logic idle;

    ////////////////////
    // routing

    assign mem_req_o  = owner_q ? odd.req : even.req;
    assign mem_addr_o = owner_q ? odd.line_addr : even.line_addr;

    assign even.ack  = mem_ack_i && !owner_q;
    assign odd.ack   = mem_ack_i && owner_q;
    assign even.line = owner_q ? '0 : mem_line_i;
    assign odd.line  = owner_q ? mem_line_i : '0;

    // port free in both directions
    assign idle = !mem_req_o && !mem_ack_i;

    ////////////////////
    // selection

    always_comb begin
        case ({even.req, odd.req})
            2'b10:   owner_d = 1'b0;
            2'b01:   owner_d = 1'b1;
            default: owner_d = !last_q; // both or none, favour the other bank
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q <= 1'b0;
            last_q  <= 1'b1; // even bank first out of reset
        end else begin
            if (idle) begin
                owner_q <= owner_d;
            end
            if (mem_req_o && mem_ack_i) begin
                last_q <= owner_q;
            end
        end
    end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter int ADDR_W  = 32,
    parameter int INDEX_W = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              init_i,
    input  logic [ADDR_W-1:0] init_addr_i,
    input  logic              resteer_i,
    input  logic [ADDR_W-5:0] wb_fip_even_i,
    input  logic [ADDR_W-5:0] wb_fip_odd_i,
    input  logic              br_taken_i,
    input  logic [ADDR_W-5:0] bp_fip_even_i,
    input  logic [ADDR_W-5:0] bp_fip_odd_i,
    input  logic              take_even_i,
    input  logic              take_odd_i,
    output line_t             line_even_o,
    output line_t             line_odd_o,
    output logic              valid_even_o,
    output logic              valid_odd_o,
    output logic              fill_even_o,
    output logic              fill_odd_o,
    output logic [1:0]        fip_even_lsb_o,
    output logic [1:0]        fip_odd_lsb_o,
    output logic              mem_req_o,
    output logic [ADDR_W-5:0] mem_addr_o,
    input  logic              mem_ack_i,
    input  line_t             mem_line_i
);

    logic [ADDR_W-5:0] fip_even;
    logic [ADDR_W-5:0] fip_odd;
    logic              fip_valid_even;
    logic              fip_valid_odd;

    refill_if #(.ADDR_W(ADDR_W)) refill_even ();
    refill_if #(.ADDR_W(ADDR_W)) refill_odd ();

    ////////////////////
    // fetch pointers

    fetch_addr_sel #(.ADDR_W(ADDR_W), .ODD(1'b0)) sel_even_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .init_i      (init_i),
        .init_addr_i (init_addr_i),
        .resteer_i   (resteer_i),
        .wb_fip_i    (wb_fip_even_i),
        .br_taken_i  (br_taken_i),
        .bp_fip_i    (bp_fip_even_i),
        .take_i      (take_even_i),
        .fip_o       (fip_even),
        .fip_valid_o (fip_valid_even),
        .src_o       ()
    );

    fetch_addr_sel #(.ADDR_W(ADDR_W), .ODD(1'b1)) sel_odd_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .init_i      (init_i),
        .init_addr_i (init_addr_i),
        .resteer_i   (resteer_i),
        .wb_fip_i    (wb_fip_odd_i),
        .br_taken_i  (br_taken_i),
        .bp_fip_i    (bp_fip_odd_i),
        .take_i      (take_odd_i),
        .fip_o       (fip_odd),
        .fip_valid_o (fip_valid_odd),
        .src_o       ()
    );

    assign fip_even_lsb_o = fip_even[1:0]; // byte address bits 5:4
    assign fip_odd_lsb_o  = fip_odd[1:0];

    ////////////////////
    // cache banks

    icache_bank #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W)) bank_even_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .fip_i       (fip_even),
        .fip_valid_i (fip_valid_even),
        .line_o      (line_even_o),
        .valid_o     (valid_even_o),
        .fill_o      (fill_even_o),
        .refill      (refill_even.bank)
    );

    icache_bank #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W)) bank_odd_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .fip_i       (fip_odd),
        .fip_valid_i (fip_valid_odd),
        .line_o      (line_odd_o),
        .valid_o     (valid_odd_o),
        .fill_o      (fill_odd_o),
        .refill      (refill_odd.bank)
    );

    // shared memory port
    refill_arbiter #(.ADDR_W(ADDR_W)) arb_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .even       (refill_even.arbiter),
        .odd        (refill_odd.arbiter),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_ack_i  (mem_ack_i),
        .mem_line_i (mem_line_i)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o; // 100 ns period
        end
    end

endmodule

`default_nettype wire

/* test/fetch_top_chk.sv */
`default_nettype none

module fetch_top_chk import fetch_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input logic              clk,
    input logic              rst_n_i,
    input logic              mem_req_i,
    input logic [ADDR_W-5:0] mem_addr_i,
    input logic              mem_ack_i,
    input logic              take_even_i,
    input logic              take_odd_i,
    input logic              valid_even_i,
    input logic              valid_odd_i,
    input bank_state_e       state_even_i,
    input bank_state_e       state_odd_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0; // polled by the testbench

    ////////////////////
    // memory port

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_i |=> !mem_req_i || $stable(mem_addr_i))
    else begin
        $error("memory address changed during a request");
        fail_count++;
    end

    req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_i && !mem_ack_i |=> mem_req_i)
    else begin
        $error("memory request dropped before its ack");
        fail_count++;
    end

    ////////////////////
    // decode side and bank fsm

    take_even_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        take_even_i |-> valid_even_i)
    else begin
        $error("even line taken while not valid");
        fail_count++;
    end

    take_odd_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        take_odd_i |-> valid_odd_i)
    else begin
        $error("odd line taken while not valid");
        fail_count++;
    end

    // lookup may only move on to a request
    lookup_exit_even: assert property (@(posedge clk) disable iff (!rst_n_i)
        state_even_i == ST_LOOKUP |=> state_even_i inside {ST_LOOKUP, ST_REQ})
    else begin
        $error("even bank left lookup toward a state other than request");
        fail_count++;
    end

    lookup_exit_odd: assert property (@(posedge clk) disable iff (!rst_n_i)
        state_odd_i == ST_LOOKUP |=> state_odd_i inside {ST_LOOKUP, ST_REQ})
    else begin
        $error("odd bank left lookup toward a state other than request");
        fail_count++;
    end

endmodule

`default_nettype wire

/* test/fetch_top_tb.sv */
`default_nettype none

module fetch_top_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W  = 32;
    localparam int INDEX_W = 4;
    localparam int TIMEOUT = 100; // cycles allowed per wait

    typedef logic [ADDR_W-5:0] fip_t;

    logic              clk;
    logic              rst_n_i;
    logic              init_i;
    logic [ADDR_W-1:0] init_addr_i;
    logic              resteer_i;
    fip_t              wb_fip_even_i;
    fip_t              wb_fip_odd_i;
    logic              br_taken_i;
    fip_t              bp_fip_even_i;
    fip_t              bp_fip_odd_i;
    logic              take_even_i;
    logic              take_odd_i;
    line_t             line_even_o;
    line_t             line_odd_o;
    logic              valid_even_o;
    logic              valid_odd_o;
    logic              fill_even_o;
    logic              fill_odd_o;
    logic [1:0]        fip_even_lsb_o;
    logic [1:0]        fip_odd_lsb_o;
    logic              mem_req_o;
    fip_t              mem_addr_o;
    logic              mem_ack_i;
    line_t             mem_line_i;

    fip_t        exp_even;                // expected pointers
    fip_t        exp_odd;
    fetch_src_e  exp_src_even = SRC_SEQ;  // expected pointer sources
    fetch_src_e  exp_src_odd  = SRC_SEQ;
    int          req_count = 0;           // requests seen by memory
    logic [31:0] rng_state = 32'd82401;

    tb_clock clock_inst (.clk_o(clk));

    fetch_top #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W)) fetch_top_inst (.*);

    bind fetch_top fetch_top_chk #(.ADDR_W(ADDR_W)) chk_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .mem_req_i    (mem_req_o),
        .mem_addr_i   (mem_addr_o),
        .mem_ack_i    (mem_ack_i),
        .take_even_i  (take_even_i),
        .take_odd_i   (take_odd_i),
        .valid_even_i (valid_even_o),
        .valid_odd_i  (valid_odd_o),
        .state_even_i (bank_even_inst.state_q),
        .state_odd_i  (bank_odd_inst.state_q)
    );

    ////////////////////
    // helpers

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // memory image: word w of line a is a ^ 32'h5a3c_0000 ^ w
    function automatic line_t mem_line(input fip_t addr);
        line_t l;
        for (int w = 0; w < LINE_W / 32; w++) begin
            l[w*32 +: 32] = 32'(addr) ^ 32'h5a3c_0000 ^ 32'(w);
        end
        return l;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_fip(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_src(input string name, input fetch_src_e exp, input fetch_src_e act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s: expected %s, actual %s", name, exp.name(),
                                act.name()));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // one-cycle redirect pulse, expected pointers by source priority
    task automatic redirect(input logic do_init, input logic [ADDR_W-1:0] addr,
                            input logic do_wb, input fip_t wb_even, input fip_t wb_odd,
                            input logic do_br, input fip_t bp_even, input fip_t bp_odd);
        fip_t init_line;
        init_line     = addr[ADDR_W-1:4];
        init_i        <= do_init;
        init_addr_i   <= addr;
        resteer_i     <= do_wb;
        wb_fip_even_i <= wb_even;
        wb_fip_odd_i  <= wb_odd;
        br_taken_i    <= do_br;
        bp_fip_even_i <= bp_even;
        bp_fip_odd_i  <= bp_odd;
        if (do_init) begin
            exp_even     = init_line[0] ? init_line + fip_t'(1) : init_line;
            exp_odd      = init_line[0] ? init_line : init_line + fip_t'(1);
            exp_src_even = SRC_INIT;
            exp_src_odd  = SRC_INIT;
        end else if (do_wb) begin
            exp_even     = wb_even;
            exp_odd      = wb_odd;
            exp_src_even = SRC_WB;
            exp_src_odd  = SRC_WB;
        end else if (do_br) begin
            exp_even     = bp_even;
            exp_odd      = bp_odd;
            exp_src_even = SRC_BP;
            exp_src_odd  = SRC_BP;
        end
        @(posedge clk);
        init_i     <= 1'b0;
        resteer_i  <= 1'b0;
        br_taken_i <= 1'b0;
    endtask

    task automatic fetch_and_check(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run({name, ": lines never became valid"});
            end
        end while (!(valid_even_o && valid_odd_o));
        check_line({name, " even line"}, mem_line(exp_even), line_even_o);
        check_line({name, " odd line"}, mem_line(exp_odd), line_odd_o);
        check_fip({name, " even lsb"}, exp_even[1:0], fip_even_lsb_o);
        check_fip({name, " odd lsb"}, exp_odd[1:0], fip_odd_lsb_o);
        check_src({name, " even source"}, exp_src_even, fetch_top_inst.sel_even_inst.src_o);
        check_src({name, " odd source"}, exp_src_odd, fetch_top_inst.sel_odd_inst.src_o);
    endtask

    // call only right after fetch_and_check, while both lines are valid
    task automatic take_lines(input logic even, input logic odd);
        take_even_i <= even;
        take_odd_i  <= odd;
        @(posedge clk);
        take_even_i <= 1'b0;
        take_odd_i  <= 1'b0;
        exp_even = even ? exp_even + fip_t'(2) : exp_even;
        exp_odd  = odd ? exp_odd + fip_t'(2) : exp_odd;
        if (even) begin
            exp_src_even = SRC_SEQ;
        end
        if (odd) begin
            exp_src_odd = SRC_SEQ;
        end
    endtask

    ////////////////////
    // memory responder

    initial begin : mem_responder
        int delay;
        int cycles;
        mem_ack_i  <= 1'b0;
        mem_line_i <= '0;
        forever begin
            @(posedge clk);
            if (mem_req_o && !mem_ack_i) begin
                req_count++;
                rng_state = xorshift(rng_state);
                delay = int'(rng_state % 6);
                repeat (delay) @(posedge clk);
                mem_line_i <= mem_line(mem_addr_o);
                mem_ack_i  <= 1'b1;
                cycles = 0;
                do begin
                    @(posedge clk);
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        abort_run("memory request stayed high after its ack");
                    end
                end while (mem_req_o);
                mem_ack_i <= 1'b0;
            end
        end
    end

    // a failed checker assertion ends the run at once
    always @(negedge clk) begin
        if (fetch_top_inst.chk_inst.fail_count != 0) begin
            abort_run("a checker assertion failed");
        end
    end

    ////////////////////
    // tests

    task automatic test_reset();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            check_bit("reset valid", 1'b0, valid_even_o | valid_odd_o);
            check_bit("reset fill", 1'b0, fill_even_o | fill_odd_o);
            check_bit("reset mem_req", 1'b0, mem_req_o);
        end
    endtask

    task automatic test_init_split();
        int base;
        base = req_count;
        redirect(1'b1, 32'h0000_1200, 1'b0, '0, '0, 1'b0, '0, '0); // bit 4 clear
        fetch_and_check("init_split even start");
        check_count("init_split even start requests", base + 2, req_count);
        base = req_count;
        redirect(1'b1, 32'h0000_3456, 1'b0, '0, '0, 1'b0, '0, '0); // bit 4 set
        fetch_and_check("init_split odd start");
        check_count("init_split odd start requests", base + 2, req_count);
    endtask

    task automatic test_sequential();
        for (int i = 0; i < 4; i++) begin
            take_lines(1'b1, 1'b1);
            fetch_and_check("sequential both");
        end
        take_lines(1'b1, 1'b0);
        fetch_and_check("sequential even");
        take_lines(1'b0, 1'b1);
        fetch_and_check("sequential odd");
    endtask

    task automatic test_hits();
        int base;
        base = req_count;
        redirect(1'b0, '0, 1'b1, 28'h348, 28'h347, 1'b0, '0, '0);
        fetch_and_check("hits cached");
        check_count("hits cached requests", base, req_count);
        redirect(1'b0, '0, 1'b1, 28'h358, 28'h347, 1'b0, '0, '0); // same even index
        fetch_and_check("hits alias");
        check_count("hits alias requests", base + 1, req_count);
        redirect(1'b0, '0, 1'b1, 28'h348, 28'h347, 1'b0, '0, '0);
        fetch_and_check("hits evicted");
        check_count("hits evicted requests", base + 2, req_count);
    endtask

    task automatic test_priority();
        redirect(1'b1, 32'h0000_0560, 1'b1, 28'h348, 28'h347, 1'b1, 28'h3a0, 28'h3a1);
        fetch_and_check("priority init");
        redirect(1'b0, '0, 1'b1, 28'h34a, 28'h349, 1'b1, 28'h3a0, 28'h3a1);
        fetch_and_check("priority resteer");
        redirect(1'b0, '0, 1'b0, '0, '0, 1'b1, 28'h3a0, 28'h3a1);
        fetch_and_check("priority branch");
    endtask

    task automatic test_dual_miss();
        int base;
        base = req_count;
        redirect(1'b0, '0, 1'b0, '0, '0, 1'b1, 28'h700, 28'h701);
        repeat (2) @(posedge clk); // both banks are refilling by now
        check_bit("dual_miss even fill", 1'b1, fill_even_o);
        check_bit("dual_miss odd fill", 1'b1, fill_odd_o);
        fetch_and_check("dual_miss");
        check_count("dual_miss requests", base + 2, req_count);
    endtask

    initial begin
        rst_n_i       <= 1'b0;
        init_i        <= 1'b0;
        init_addr_i   <= '0;
        resteer_i     <= 1'b0;
        wb_fip_even_i <= '0;
        wb_fip_odd_i  <= '0;
        br_taken_i    <= 1'b0;
        bp_fip_even_i <= '0;
        bp_fip_odd_i  <= '0;
        take_even_i   <= 1'b0;
        take_odd_i    <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset();
        test_init_split();
        test_sequential();
        test_hits();
        test_priority();
        test_dual_miss();
        if (fetch_top_inst.chk_inst.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
common/fetch_pkg.sv
common/refill_if.sv
source/fetch_addr_sel.sv
icache/icache_bank.sv
icache/refill_arbiter.sv
source/fetch_top.sv
test/tb_clock.sv
test/fetch_top_chk.sv
test/fetch_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fetch_top_tb
FILELIST  := all.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
